//--- Bender.yml
package:
  name: ccu_read

sources:
  - ccu_bus_pkg.sv
  - ccu_snoop_pkg.sv
  - ccu_read_decoder.sv
  - ccu_snoop_ctrl.sv
  - ccu_read_result.sv
  - ccu_read_top.sv
  - target: test
    files:
      - tb_ccu_read.sv

//--- build.f
ccu_bus_pkg.sv
ccu_snoop_pkg.sv
ccu_read_decoder.sv
ccu_snoop_ctrl.sv
ccu_read_result.sv
ccu_read_top.sv
tb_ccu_read.sv

//--- ccu_bus_pkg.sv
`default_nettype none

package ccu_bus_pkg;

    // ----------------------------------------------------------------------
    // Wishbone classic request, shared by core, snoop and memory ports
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [7:0]  tga;   // Tag word or snoop op code
    } wb_req_t;

    // ----------------------------------------------------------------------
    // Wishbone classic response
    // ----------------------------------------------------------------------
    // tgd[1] data valid, tgd[0] line was dirty
    // Only the snoop port drives tgd
    typedef struct packed {
        logic        ack;
        logic        err;
        logic [63:0] dat;
        logic [1:0]  tgd;
    } wb_rsp_t;

    // Index into tgd
    localparam int unsigned TgdValid = 1;
    localparam int unsigned TgdDirty = 0;

endpackage

`default_nettype wire

//--- ccu_read_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_read_decoder (
    input  wire                       rst_n,
    input  wire                       rst_n_i,
    input  ccu_bus_pkg::wb_req_t      core_req_i,
    input  wire                       idle_i,
    output logic                      start_o,
    output ccu_snoop_pkg::rd_info_t   info_o
);

    ccu_snoop_pkg::rd_tag_u  tag;
    ccu_snoop_pkg::rd_info_t info_d;
    logic                    busy_q;
    logic                    accept;

    assign tag    = core_req_i.tga;
    assign accept = core_req_i.cyc & core_req_i.stb & ~busy_q;

    // ----------------------------------------------------------------------
    // Tag word decode
    // ----------------------------------------------------------------------
    always_comb begin
        info_d     = '0;
        info_d.adr = core_req_i.adr;
        if (tag.plain.flag == 1'b0) begin
            info_d.coherent   = 1'b0;
            info_d.op         = ccu_snoop_pkg::READ_ONCE;
            info_d.needs_data = 1'b1;
        end else begin
            info_d.coherent = 1'b1;
            if (tag.coh.op > ccu_snoop_pkg::LastLegalOp) begin
                info_d.illegal = 1'b1;
                info_d.op      = ccu_snoop_pkg::READ_ONCE;
            end else begin
                info_d.op = ccu_snoop_pkg::snoop_op_e'(tag.coh.op);
            end
            info_d.needs_data = (info_d.op != ccu_snoop_pkg::CLEAN_UNIQUE);
        end
        if (core_req_i.we) begin
            info_d.illegal = 1'b1; // Writes not supported
        end
    end

    // ----------------------------------------------------------------------
    // Request latch
    // ----------------------------------------------------------------------
    always_ff @(posedge rst_n) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            start_o <= 1'b0;
        end else begin
            start_o <= accept;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (idle_i) begin
                busy_q <= 1'b0;     // Answer sent
            end
        end
    end

    always_ff @(posedge rst_n) begin
        if (accept) begin
            info_o <= info_d;
        end
    end

endmodule

`default_nettype wire

//--- ccu_read_result.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_read_result #(
    parameter int unsigned DataWidth = 64
) (
    input  wire                       rst_n,
    input  wire                       rst_n_i,
    input  wire                       done_i,
    input  wire                       src_snoop_i,
    input  wire                       zero_data_i,
    input  wire                       illegal_i,
    input  wire  [DataWidth-1:0]      snoop_dat_i,
    input  wire  [DataWidth-1:0]      mem_dat_i,
    output ccu_bus_pkg::wb_rsp_t      core_rsp_o,
    output logic                      idle_o
);

    logic [DataWidth-1:0] dat_q;
    logic                 ack_q;
    logic                 err_q;

    // ----------------------------------------------------------------------
    // Answer data select
    // ----------------------------------------------------------------------
    always_ff @(posedge rst_n) begin
        if (done_i) begin
            if (zero_data_i) begin
                dat_q <= '0;
            end else if (src_snoop_i) begin
                dat_q <= snoop_dat_i;
            end else begin
                dat_q <= mem_dat_i;
            end
        end
    end

    // One-cycle answer pulse
    always_ff @(posedge rst_n) begin
        if (!rst_n_i) begin
            ack_q  <= 1'b0;
            err_q  <= 1'b0;
            idle_o <= 1'b0;
        end else begin
            ack_q  <= done_i & ~illegal_i;
            err_q  <= done_i & illegal_i;
            idle_o <= done_i;          // Frees the decoder
        end
    end

    always_comb begin
        core_rsp_o     = '0;
        core_rsp_o.ack = ack_q;
        core_rsp_o.err = err_q;
        core_rsp_o.dat = dat_q;
    end

endmodule

`default_nettype wire

//--- ccu_read_top.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_read_top #(
    parameter int unsigned DataWidth = 64
) (
    input  wire                       rst_n,
    input  wire                       rst_n_i,
    input  ccu_bus_pkg::wb_req_t      core_req_i,
    output ccu_bus_pkg::wb_rsp_t      core_rsp_o,
    output ccu_bus_pkg::wb_req_t      snoop_req_o,
    input  ccu_bus_pkg::wb_rsp_t      snoop_rsp_i,
    output ccu_bus_pkg::wb_req_t      mem_req_o,
    input  ccu_bus_pkg::wb_rsp_t      mem_rsp_i
);

    ccu_snoop_pkg::rd_info_t info;
    logic                    start;
    logic                    idle;
    logic                    done;
    logic                    src_snoop;
    logic                    zero_data;
    logic                    illegal;
    logic [DataWidth-1:0]    snoop_dat;
    logic [DataWidth-1:0]    mem_dat;

    // ----------------------------------------------------------------------
    // Decode, execute, result
    // ----------------------------------------------------------------------
    ccu_read_decoder u_decoder (
        .rst_n      (rst_n),
        .rst_n_i    (rst_n_i),
        .core_req_i (core_req_i),
        .idle_i     (idle),
        .start_o    (start),
        .info_o     (info)
    );

    ccu_snoop_ctrl u_snoop_ctrl (
        .rst_n       (rst_n),
        .rst_n_i     (rst_n_i),
        .start_i     (start),
        .info_i      (info),
        .snoop_req_o (snoop_req_o),
        .snoop_rsp_i (snoop_rsp_i),
        .mem_req_o   (mem_req_o),
        .mem_rsp_i   (mem_rsp_i),
        .done_o      (done),
        .src_snoop_o (src_snoop),
        .zero_data_o (zero_data),
        .illegal_o   (illegal),
        .snoop_dat_o (snoop_dat),
        .mem_dat_o   (mem_dat)
    );

    ccu_read_result #(
        .DataWidth (DataWidth)
    ) u_result (
        .rst_n       (rst_n),
        .rst_n_i     (rst_n_i),
        .done_i      (done),
        .src_snoop_i (src_snoop),
        .zero_data_i (zero_data),
        .illegal_i   (illegal),
        .snoop_dat_i (snoop_dat),
        .mem_dat_i   (mem_dat),
        .core_rsp_o  (core_rsp_o),
        .idle_o      (idle)
    );

endmodule

`default_nettype wire

//--- ccu_snoop_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_snoop_ctrl (
    input  wire                       rst_n,
    input  wire                       rst_n_i,
    input  wire                       start_i,
    input  ccu_snoop_pkg::rd_info_t   info_i,
    output ccu_bus_pkg::wb_req_t      snoop_req_o,
    input  ccu_bus_pkg::wb_rsp_t      snoop_rsp_i,
    output ccu_bus_pkg::wb_req_t      mem_req_o,
    input  ccu_bus_pkg::wb_rsp_t      mem_rsp_i,
    output logic                      done_o,
    output logic                      src_snoop_o,
    output logic                      zero_data_o,
    output logic                      illegal_o,
    output logic [63:0]               snoop_dat_o,
    output logic [63:0]               mem_dat_o
);

    typedef enum logic [1:0] {
        IDLE,
        SNOOP,
        MEM,
        DONE
    } state_e;

    state_e state_q;
    logic   snoop_hit;
    logic   clean_unique;

    assign clean_unique = (info_i.op == ccu_snoop_pkg::CLEAN_UNIQUE);
    assign snoop_hit    = snoop_rsp_i.tgd[ccu_bus_pkg::TgdValid] & info_i.needs_data;

    // ----------------------------------------------------------------------
    // Bus requests, held for the whole state
    // ----------------------------------------------------------------------
    always_comb begin
        snoop_req_o     = '0;
        snoop_req_o.cyc = (state_q == SNOOP);
        snoop_req_o.stb = (state_q == SNOOP);
        snoop_req_o.adr = info_i.adr;
        snoop_req_o.tga = 8'(info_i.op);   // Op code rides in tga

        mem_req_o     = '0;
        mem_req_o.cyc = (state_q == MEM);
        mem_req_o.stb = (state_q == MEM);
        mem_req_o.adr = info_i.adr;
    end

    assign done_o = (state_q == DONE);

    // ----------------------------------------------------------------------
    // FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge rst_n) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            src_snoop_o <= 1'b0;
            zero_data_o <= 1'b0;
            illegal_o   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        src_snoop_o <= 1'b0;
                        zero_data_o <= 1'b0;
                        illegal_o   <= info_i.illegal;
                        if (info_i.illegal) begin
                            state_q <= DONE;   // No bus access
                        end else if (info_i.coherent) begin
                            state_q <= SNOOP;
                        end else begin
                            state_q <= MEM;
                        end
                    end
                end
                SNOOP: begin
                    if (snoop_rsp_i.ack) begin
                        if (clean_unique) begin
                            zero_data_o <= 1'b1;
                            state_q     <= DONE;
                        end else if (snoop_hit) begin
                            src_snoop_o <= 1'b1;  // Peer data answers
                            state_q     <= DONE;
                        end else begin
                            state_q <= MEM;
                        end
                    end
                end
                MEM: begin
                    if (mem_rsp_i.ack) begin
                        state_q <= DONE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Captured read data
    always_ff @(posedge rst_n) begin
        if (state_q == SNOOP && snoop_rsp_i.ack) begin
            snoop_dat_o <= snoop_rsp_i.dat;
        end
        if (state_q == MEM && mem_rsp_i.ack) begin
            mem_dat_o <= mem_rsp_i.dat;
        end
    end

endmodule

`default_nettype wire

//--- ccu_snoop_pkg.sv
`default_nettype none

package ccu_snoop_pkg;

    // Coherent read kinds, codes 5 to 7 are illegal
    typedef enum logic [2:0] {
        READ_ONCE    = 3'd0,
        READ_SHARED  = 3'd1,
        READ_CLEAN   = 3'd2,
        READ_UNIQUE  = 3'd3,
        CLEAN_UNIQUE = 3'd4
    } snoop_op_e;

    localparam logic [2:0] LastLegalOp = 3'd4;

    // ----------------------------------------------------------------------
    // Tag word views
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic       flag;     // 1 for coherent
        logic [2:0] op;
        logic [3:0] domain;
    } rd_tag_coh_t;

    typedef struct packed {
        logic       flag;     // 0 for plain
        logic [2:0] rsvd;
        logic [3:0] attr;     // Cache attributes
    } rd_tag_plain_t;

    typedef union packed {
        rd_tag_coh_t   coh;
        rd_tag_plain_t plain;
    } rd_tag_u;

    // Decoded read handed from decoder to execute stage
    typedef struct packed {
        logic        coherent;
        snoop_op_e   op;
        logic        needs_data;
        logic        illegal;
        logic [31:0] adr;
    } rd_info_t;

endpackage

`default_nettype wire

//--- tb_ccu_read.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ccu_read;

    localparam int ClkPeriod = 40;
    localparam int MaxWait   = 30;     // Cycles per request before giving up

    localparam logic [1:0] SrcMem   = 2'd0;
    localparam logic [1:0] SrcSnoop = 2'd1;
    localparam logic [1:0] SrcZero  = 2'd2;
    localparam logic [1:0] SrcErr   = 2'd3;

    typedef struct packed {
        logic [31:0] adr;
        logic        we;
        logic [7:0]  tga;
        logic        peer_valid;
        logic        peer_dirty;
        logic        exp_snoop;    // Peer gets snooped
        logic [1:0]  exp_src;
    } row_t;

    logic                 rst_n;
    logic                 rst_n_i;
    ccu_bus_pkg::wb_req_t core_req;
    ccu_bus_pkg::wb_rsp_t core_rsp;
    ccu_bus_pkg::wb_req_t snoop_req;
    ccu_bus_pkg::wb_rsp_t snoop_rsp;
    ccu_bus_pkg::wb_req_t mem_req;
    ccu_bus_pkg::wb_rsp_t mem_rsp;

    row_t        rows[$];
    logic        table_loaded;
    logic [31:0] rng;
    logic        peer_valid;
    logic        peer_dirty;
    logic        snoop_armed;
    logic        mem_armed;
    logic [1:0]  snoop_wait;
    logic [1:0]  mem_wait;
    logic        snoop_seen;
    logic [7:0]  snoop_tga;
    logic        mem_seen;
    int          ack_cnt;
    int          err_cnt;
    int          errors;
    int          passed;

    ccu_read_top #(
        .DataWidth (64)
    ) dut0 (
        .rst_n       (rst_n),
        .rst_n_i     (rst_n_i),
        .core_req_i  (core_req),
        .core_rsp_o  (core_rsp),
        .snoop_req_o (snoop_req),
        .snoop_rsp_i (snoop_rsp),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp)
    );

    always #(ClkPeriod / 2) rst_n = ~rst_n;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [63:0] expected_dat(input logic [1:0] src, input logic [31:0] adr);
        if (src == SrcMem) begin
            return {32'h0, adr} + 64'h1000;
        end else if (src == SrcSnoop) begin
            return {32'h0, adr} ^ 64'hC0FFEE;
        end
        return 64'h0;
    endfunction

    task automatic add_row(input logic [31:0] adr, input logic we, input logic [7:0] tga,
                           input logic pv, input logic pd, input logic snp,
                           input logic [1:0] src);
        row_t r;
        r = {adr, we, tga, pv, pd, snp, src};
        rows.push_back(r);
    endtask

    task automatic report_mismatch(input string where, input string name,
                                   input logic [63:0] got, input logic [63:0] exp);
        $display("[ERROR] %s %s got %h expected %h", where, name, got, exp);
        errors = errors + 1;
    endtask

    // ----------------------------------------------------------------------
    // Peer cache and memory responders
    // ----------------------------------------------------------------------
    always @(posedge rst_n) begin
        #2;
        if (snoop_rsp.ack) begin
            snoop_rsp.ack = 1'b0;      // One-cycle pulse
            snoop_armed   = 1'b0;
        end else if (snoop_req.cyc && snoop_req.stb) begin
            if (!snoop_armed) begin
                rng         = xorshift32(rng);
                snoop_wait  = rng[1:0];
                snoop_armed = 1'b1;
            end
            if (snoop_wait == 2'd0) begin
                snoop_rsp.ack = 1'b1;
                snoop_rsp.dat = {32'h0, snoop_req.adr} ^ 64'hC0FFEE;
                snoop_rsp.tgd = {peer_valid, peer_dirty};
            end else begin
                snoop_wait = snoop_wait - 2'd1;
            end
        end
        if (mem_rsp.ack) begin
            mem_rsp.ack = 1'b0;
            mem_armed   = 1'b0;
        end else if (mem_req.cyc && mem_req.stb) begin
            if (!mem_armed) begin
                rng       = xorshift32(rng);
                mem_wait  = rng[1:0];
                mem_armed = 1'b1;
            end
            if (mem_wait == 2'd0) begin
                mem_rsp.ack = 1'b1;
                mem_rsp.dat = {32'h0, mem_req.adr} + 64'h1000;
            end else begin
                mem_wait = mem_wait - 2'd1;
            end
        end
    end

    // Bus activity seen during a row
    always @(negedge rst_n) begin
        if (core_rsp.ack === 1'b1) ack_cnt = ack_cnt + 1;
        if (core_rsp.err === 1'b1) err_cnt = err_cnt + 1;
        if (snoop_req.cyc === 1'b1) begin
            snoop_seen = 1'b1;
            snoop_tga  = snoop_req.tga;
        end
        if (mem_req.cyc === 1'b1) mem_seen = 1'b1;
    end

    task automatic run_row(input int idx);
        row_t        r;
        string       where;
        int          cycles;
        int          start_errors;
        logic        answered;
        logic        exp_err;
        logic [7:0]  exp_tga;
        logic [63:0] got_dat;
        r            = rows[idx];
        where        = $sformatf("row %0d", idx);
        start_errors = errors;
        exp_err      = (r.exp_src == SrcErr);
        exp_tga      = {5'b0, r.tga[6:4]};  // Op field of the coherent view
        peer_valid   = r.peer_valid;
        peer_dirty   = r.peer_dirty;
        ack_cnt      = 0;
        err_cnt      = 0;
        snoop_seen   = 1'b0;
        snoop_tga    = '0;
        mem_seen     = 1'b0;
        core_req     = {1'b1, 1'b1, r.we, r.adr, r.tga};
        cycles       = 0;
        answered     = 1'b0;
        got_dat      = '0;
        while (!answered && cycles < MaxWait) begin
            @(posedge rst_n);
            #1;
            cycles = cycles + 1;
            if (core_rsp.ack || core_rsp.err) begin
                answered = 1'b1;
                got_dat  = core_rsp.dat;
            end
        end
        @(posedge rst_n);
        #2;
        core_req = '0;
        repeat (3) @(posedge rst_n);  // Room for a stray second answer
        #2;
        if (!answered) begin
            $display("[ERROR] %s the DUT gave neither ack nor err in time", where);
            errors = errors + 1;
        end else begin
            if (ack_cnt != (exp_err ? 0 : 1)) report_mismatch(where, "ack count", ack_cnt, !exp_err);
            if (err_cnt != (exp_err ? 1 : 0)) report_mismatch(where, "err count", err_cnt, exp_err);
            if (snoop_seen != r.exp_snoop) begin
                report_mismatch(where, "snoop_req_o.cyc", snoop_seen, r.exp_snoop);
            end
            if (r.exp_snoop && snoop_tga != exp_tga) begin
                report_mismatch(where, "snoop_req_o.tga", snoop_tga, exp_tga);
            end
            if (mem_seen != (r.exp_src == SrcMem)) begin
                report_mismatch(where, "mem_req_o.cyc", mem_seen, r.exp_src == SrcMem);
            end
            if (exp_err && cycles != 3) report_mismatch(where, "err latency", cycles, 3);
            if (!exp_err && got_dat != expected_dat(r.exp_src, r.adr)) begin
                report_mismatch(where, "core_rsp_o.dat", got_dat, expected_dat(r.exp_src, r.adr));
            end
        end
        if (errors == start_errors) begin
            passed = passed + 1;
            $display("%s adr %h tga %h ok", where, r.adr, r.tga);
        end else begin
            $display("%s adr %h tga %h failed", where, r.adr, r.tga);
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        rst_n        = 1'b0;
        rst_n_i      = 1'b0;
        core_req     = '0;
        snoop_rsp    = '0;
        mem_rsp      = '0;
        rng          = 32'h7f37;
        peer_valid   = 1'b0;
        peer_dirty   = 1'b0;
        snoop_armed  = 1'b0;
        mem_armed    = 1'b0;
        snoop_wait   = '0;
        mem_wait     = '0;
        snoop_seen   = 1'b0;
        snoop_tga    = '0;
        mem_seen     = 1'b0;
        ack_cnt      = 0;
        err_cnt      = 0;
        errors       = 0;
        passed       = 0;
        // adr, we, tga, peer valid, peer dirty, snooped, source
        add_row(32'h0000_0100, 1'b0, 8'h05, 1'b0, 1'b0, 1'b0, SrcMem);    // Plain
        add_row(32'h0000_2a40, 1'b0, 8'h7a, 1'b1, 1'b0, 1'b0, SrcMem);
        add_row(32'h0001_0080, 1'b0, 8'h93, 1'b1, 1'b1, 1'b1, SrcSnoop);  // READ_SHARED dirty
        add_row(32'h0001_00c0, 1'b0, 8'h90, 1'b1, 1'b0, 1'b1, SrcSnoop);
        add_row(32'h0002_0000, 1'b0, 8'h81, 1'b0, 1'b0, 1'b1, SrcMem);    // READ_ONCE miss
        add_row(32'h0002_0040, 1'b0, 8'ha0, 1'b1, 1'b0, 1'b1, SrcSnoop);
        add_row(32'h0003_1000, 1'b0, 8'hb0, 1'b0, 1'b0, 1'b1, SrcMem);
        add_row(32'h0004_0200, 1'b0, 8'hc0, 1'b1, 1'b1, 1'b1, SrcZero);   // CLEAN_UNIQUE
        add_row(32'h0004_0240, 1'b0, 8'hc5, 1'b0, 1'b0, 1'b1, SrcZero);
        add_row(32'h0005_0000, 1'b0, 8'hd0, 1'b1, 1'b0, 1'b0, SrcErr);    // Op 5 to 7
        add_row(32'h0005_0040, 1'b0, 8'he0, 1'b1, 1'b0, 1'b0, SrcErr);
        add_row(32'h0005_0080, 1'b0, 8'hf3, 1'b1, 1'b0, 1'b0, SrcErr);
        add_row(32'h0006_0000, 1'b1, 8'h00, 1'b0, 1'b0, 1'b0, SrcErr);    // Writes
        add_row(32'h0006_0040, 1'b1, 8'h90, 1'b1, 1'b0, 1'b0, SrcErr);
        table_loaded = 1'b1;

        repeat (4) @(posedge rst_n);
        #2;
        rst_n_i = 1'b1;
        if ({snoop_req.cyc, snoop_req.stb} !== 2'b00) begin
            report_mismatch("reset", "snoop_req_o.cyc/stb", {snoop_req.cyc, snoop_req.stb}, 0);
        end
        if ({mem_req.cyc, mem_req.stb} !== 2'b00) begin
            report_mismatch("reset", "mem_req_o.cyc/stb", {mem_req.cyc, mem_req.stb}, 0);
        end
        if ({core_rsp.ack, core_rsp.err} !== 2'b00) begin
            report_mismatch("reset", "core_rsp_o.ack/err", {core_rsp.ack, core_rsp.err}, 0);
        end

        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end

        $display("Tests %0d, passed %0d, errors %0d", rows.size(), passed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog, 40 cycles per row plus reset
    initial begin
        wait (table_loaded === 1'b1);
        #((rows.size() * 40 + 4) * ClkPeriod);
        $display("Timeout after %0d cycles, the tests did not finish", rows.size() * 40 + 4);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire
